//--- Makefile
# Verilator build and run for the shared-bus fabric testbench

VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/soc_properties.sv
`timescale 1ns/10ps
`default_nettype none

module soc_properties (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        core_gnt_i,
  input logic        core_rvalid_i,
  input logic        dbg_gnt_i,
  input logic        dbg_rvalid_i,
  input logic        timer_irq_i,
  input logic        ipi_i,
  input logic [31:0] exit_i
);

  // ------------------------------------------------
  // Arbitration
  // ------------------------------------------------
  one_grant_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core_gnt_i && dbg_gnt_i))
    else $error("core and debug grants high in the same cycle");

  // Response exactly one cycle after each grant
  core_resp_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_gnt_i |=> core_rvalid_i)
    else $error("core grant not followed by rvalid");

  core_src_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_rvalid_i |-> $past(core_gnt_i))
    else $error("core rvalid without a grant in the previous cycle");

  dbg_resp_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_gnt_i |=> dbg_rvalid_i)
    else $error("debug grant not followed by rvalid");

  dbg_src_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_rvalid_i |-> $past(dbg_gnt_i))
    else $error("debug rvalid without a grant in the previous cycle");

  // ------------------------------------------------
  // Outputs quiet in reset
  // ------------------------------------------------
  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> (!timer_irq_i && !ipi_i && (exit_i == 32'h0)))
    else $error("timer_irq, ipi or exit word active during reset");

endmodule

`default_nettype wire

//--- bench/soc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module soc_tb import bus_pkg::*, soc_map_pkg::*; ();

  localparam int          ClkHalf   = 50;
  localparam logic [31:0] Seed      = 32'h69a85c50;
  localparam logic        PortCore  = 1'b0;
  localparam logic        PortDbg   = 1'b1;
  localparam int          RtcPulses = 5;
  localparam int          IrqWait   = 20;
  localparam addr_t       SramA     = SramBase + 32'h0000_0100;
  localparam addr_t       SramB     = SramBase + 32'h0000_0208;
  localparam addr_t       ShareCore = SramBase + 32'h0000_0040;
  localparam addr_t       ShareDbg  = SramBase + 32'h0000_0048;

  typedef struct packed {
    logic  port;
    logic  we;
    addr_t addr;
    strb_t be;
    data_t wdata;
    data_t exp_rdata;
    logic  exp_err;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        rtc;
  logic        core_req;
  logic        core_we;
  addr_t       core_addr;
  strb_t       core_be;
  data_t       core_wdata;
  logic        core_gnt;
  logic        core_rvalid;
  data_t       core_rdata;
  logic        core_err;
  logic        dbg_req;
  logic        dbg_we;
  addr_t       dbg_addr;
  strb_t       dbg_be;
  data_t       dbg_wdata;
  logic        dbg_gnt;
  logic        dbg_rvalid;
  data_t       dbg_rdata;
  logic        dbg_err;
  logic [31:0] exit_val;
  logic        timer_irq;
  logic        ipi;

  string  names[$];
  entry_t entries[$];
  data_t  exit_data;
  int     pass_cnt    = 0;
  int     fail_cnt    = 0;
  int     cycle_cnt   = 0;
  int     cycle_limit = 1000;

  soc_top dut0 (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .rtc_i         ( rtc         ),
    .core_req_i    ( core_req    ),
    .core_we_i     ( core_we     ),
    .core_addr_i   ( core_addr   ),
    .core_be_i     ( core_be     ),
    .core_wdata_i  ( core_wdata  ),
    .core_gnt_o    ( core_gnt    ),
    .core_rvalid_o ( core_rvalid ),
    .core_rdata_o  ( core_rdata  ),
    .core_err_o    ( core_err    ),
    .dbg_req_i     ( dbg_req     ),
    .dbg_we_i      ( dbg_we      ),
    .dbg_addr_i    ( dbg_addr    ),
    .dbg_be_i      ( dbg_be      ),
    .dbg_wdata_i   ( dbg_wdata   ),
    .dbg_gnt_o     ( dbg_gnt     ),
    .dbg_rvalid_o  ( dbg_rvalid  ),
    .dbg_rdata_o   ( dbg_rdata   ),
    .dbg_err_o     ( dbg_err     ),
    .exit_o        ( exit_val    ),
    .timer_irq_o   ( timer_irq   ),
    .ipi_o         ( ipi         )
  );

  bind soc_top soc_properties props0 (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .core_gnt_i    ( core_gnt_o    ),
    .core_rvalid_i ( core_rvalid_o ),
    .dbg_gnt_i     ( dbg_gnt_o     ),
    .dbg_rvalid_i  ( dbg_rvalid_o  ),
    .timer_irq_i   ( timer_irq_o   ),
    .ipi_i         ( ipi_o         ),
    .exit_i        ( exit_o        )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(ClkHalf) clk = ~clk;
    end
  end

  // Watchdog on the total cycle count
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, a transfer or wait never finished", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  // Expected word after a byte-enabled write
  function automatic data_t byte_merge(data_t old_word, data_t new_word, strb_t mask_be);
    data_t mask;
    mask = '0;
    for (int b = 0; b < StrbWidth; b++) begin
      mask[8*b +: 8] = {8{mask_be[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic drive_port(input logic port, input logic req, input logic we,
                            input addr_t addr, input strb_t be, input data_t wdata);
    if (port == PortCore) begin
      core_req   = req;
      core_we    = we;
      core_addr  = addr;
      core_be    = be;
      core_wdata = wdata;
    end else begin
      dbg_req   = req;
      dbg_we    = we;
      dbg_addr  = addr;
      dbg_be    = be;
      dbg_wdata = wdata;
    end
  endtask

  function automatic logic port_gnt(input logic port);
    return (port == PortCore) ? core_gnt : dbg_gnt;
  endfunction

  // Drive on the falling edge, sample grant mid low phase
  task automatic bus_xfer(input logic port, input logic we, input addr_t addr,
                          input strb_t be, input data_t wdata, output data_t rdata,
                          output logic err, output int gnt_cycle);
    logic granted;
    logic rvalid;
    granted   = 1'b0;
    gnt_cycle = 0;
    @(negedge clk);
    drive_port(port, 1'b1, we, addr, be, wdata);
    while (!granted) begin
      #(ClkHalf / 2);
      granted   = port_gnt(port);
      gnt_cycle = cycle_cnt;
      @(negedge clk);
    end
    drive_port(port, 1'b0, 1'b0, '0, '0, '0);
    rvalid = (port == PortCore) ? core_rvalid : dbg_rvalid;
    rdata  = (port == PortCore) ? core_rdata : dbg_rdata;
    err    = (port == PortCore) ? core_err : dbg_err;
    if (!rvalid) begin
      $display("No response one cycle after the grant on port %0d, addr %h", port, addr);
      fail_cnt++;
    end
  endtask

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      fail_cnt++;
    end else begin
      $display("[PASS] %s", name);
      pass_cnt++;
    end
  endtask

  task automatic check_response(input string name, input data_t exp_rdata,
                                input data_t act_rdata, input logic exp_err,
                                input logic act_err);
    if (act_rdata !== exp_rdata) begin
      $display("[FAIL] %s rdata expected %h actual %h", name, exp_rdata, act_rdata);
      fail_cnt++;
    end else if (act_err !== exp_err) begin
      $display("[FAIL] %s err expected %b actual %b", name, exp_err, act_err);
      fail_cnt++;
    end else begin
      $display("[PASS] %s", name);
      pass_cnt++;
    end
  endtask

  task automatic add_entry(input string name, input logic port, input logic we,
                           input addr_t addr, input strb_t be, input data_t wdata,
                           input data_t exp_rdata, input logic exp_err);
    entry_t e;
    e.port      = port;
    e.we        = we;
    e.addr      = addr;
    e.be        = be;
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    names.push_back(name);
    entries.push_back(e);
  endtask

  // ------------------------------------------------
  // Stimulus table
  // ------------------------------------------------
  task automatic build_table();
    data_t fill_a;
    data_t part_a;
    data_t fill_b;
    data_t part_b;
    fill_a    = {$urandom, $urandom};
    part_a    = {$urandom, $urandom};
    fill_b    = {$urandom, $urandom};
    part_b    = {$urandom, $urandom};
    exit_data = {$urandom, $urandom};
    add_entry("sram_fill_core", PortCore, 1'b1, SramA, 8'hFF, fill_a, '0, 1'b0);
    add_entry("sram_part_dbg", PortDbg, 1'b1, SramA, 8'h0F, part_a, '0, 1'b0);
    add_entry("sram_merge_core", PortCore, 1'b0, SramA, 8'h00, '0,
              byte_merge(fill_a, part_a, 8'h0F), 1'b0);
    add_entry("sram_fill_dbg", PortDbg, 1'b1, SramB, 8'hFF, fill_b, '0, 1'b0);
    add_entry("sram_part_core", PortCore, 1'b1, SramB, 8'hA5, part_b, '0, 1'b0);
    add_entry("sram_merge_dbg", PortDbg, 1'b0, SramB, 8'h00, '0,
              byte_merge(fill_b, part_b, 8'hA5), 1'b0);
    add_entry("rom_word0", PortCore, 1'b0, RomBase, 8'h00, '0, RomSignature, 1'b0);
    add_entry("rom_word5", PortDbg, 1'b0, RomBase + 32'h28, 8'h00, '0,
              RomSignature ^ 64'd5, 1'b0);
    add_entry("rom_word511", PortCore, 1'b0, RomBase + 32'hFF8, 8'h00, '0,
              RomSignature ^ 64'd511, 1'b0);
    add_entry("rom_write", PortCore, 1'b1, RomBase + 32'h8, 8'hFF, fill_a, '0, 1'b1);
    add_entry("unmapped_read", PortCore, 1'b0, 32'h4000_0000, 8'h00, '0, '0, 1'b1);
    add_entry("unmapped_write", PortDbg, 1'b1, 32'h1000_0000, 8'hFF, fill_b, '0, 1'b1);
    add_entry("clint_cmp_reset", PortCore, 1'b0, ClintBase + ClintMtimecmpOff, 8'h00, '0,
              {64{1'b1}}, 1'b0);
    add_entry("exit_write", PortCore, 1'b1, ExitAddr, 8'hFF, exit_data, '0, 1'b0);
    add_entry("exit_readback", PortDbg, 1'b0, ExitAddr, 8'h00, '0, exit_data, 1'b0);
  endtask

  initial begin
    data_t rd_core;
    data_t rd_dbg;
    data_t wd_core;
    data_t wd_dbg;
    data_t rdata;
    data_t mtime_first;
    logic  err_core;
    logic  err_dbg;
    logic  err;
    int    gc_core;
    int    gc_dbg;
    int    gcyc;
    int    waited;

    void'($urandom(Seed));
    rst_n = 1'b1;
    rtc   = 1'b0;
    drive_port(PortCore, 1'b0, 1'b0, '0, '0, '0);
    drive_port(PortDbg, 1'b0, 1'b0, '0, '0, '0);
    build_table();
    cycle_limit = 20 * entries.size() + 200;

    #1 rst_n = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Both ports at once, core first after reset
    wd_core = {$urandom, $urandom};
    wd_dbg  = {$urandom, $urandom};
    fork
      bus_xfer(PortCore, 1'b1, ShareCore, 8'hFF, wd_core, rd_core, err_core, gc_core);
      bus_xfer(PortDbg, 1'b1, ShareDbg, 8'hFF, wd_dbg, rd_dbg, err_dbg, gc_dbg);
    join
    check_value("contend_write_order", data_t'(1), data_t'(gc_dbg - gc_core));
    check_value("contend_write_err", '0, data_t'({err_core, err_dbg}));

    fork
      bus_xfer(PortCore, 1'b0, ShareCore, 8'h00, '0, rd_core, err_core, gc_core);
      bus_xfer(PortDbg, 1'b0, ShareDbg, 8'h00, '0, rd_dbg, err_dbg, gc_dbg);
    join
    check_value("contend_read_order", data_t'(1), data_t'(gc_dbg - gc_core));
    check_value("contend_read_core", wd_core, rd_core);
    check_value("contend_read_dbg", wd_dbg, rd_dbg);

    foreach (entries[i]) begin
      bus_xfer(entries[i].port, entries[i].we, entries[i].addr, entries[i].be,
               entries[i].wdata, rdata, err, gcyc);
      check_response(names[i], entries[i].exp_rdata, rdata, entries[i].exp_err, err);
    end
    check_value("exit_word", data_t'(exit_data[31:0]), data_t'(exit_val));

    // ------------------------------------------------
    // CLINT timer and software interrupt
    // ------------------------------------------------
    bus_xfer(PortCore, 1'b1, ClintBase + ClintMtimecmpOff, 8'hFF, 64'd3, rdata, err, gcyc);
    check_response("clint_cmp_write", '0, rdata, 1'b0, err);
    check_value("timer_irq_before_ticks", '0, data_t'(timer_irq));

    repeat (RtcPulses) begin
      repeat (4) @(negedge clk);
      rtc = 1'b1;
      repeat (4) @(negedge clk);
      rtc = 1'b0;
    end

    waited = 0;
    while (!timer_irq && waited < IrqWait) begin
      @(negedge clk);
      waited++;
    end
    if (!timer_irq) begin
      $display("Timer interrupt did not rise within %0d cycles after the rtc ticks", IrqWait);
      fail_cnt++;
    end else begin
      $display("[PASS] timer_irq_rise");
      pass_cnt++;
    end

    // One more rtc tick between the two mtime reads
    bus_xfer(PortDbg, 1'b0, ClintBase + ClintMtimeOff, 8'h00, '0, mtime_first, err, gcyc);
    @(negedge clk);
    rtc = 1'b1;
    repeat (4) @(negedge clk);
    rtc = 1'b0;
    repeat (4) @(negedge clk);

    bus_xfer(PortCore, 1'b0, ClintBase + ClintMtimeOff, 8'h00, '0, rdata, err, gcyc);
    if (rdata > mtime_first) begin
      $display("[PASS] mtime_monotonic");
      pass_cnt++;
    end else begin
      $display("mtime did not advance from %h to %h after an rtc tick", mtime_first, rdata);
      fail_cnt++;
    end

    bus_xfer(PortCore, 1'b1, ClintBase + ClintMsipOff, 8'h01, 64'd1, rdata, err, gcyc);
    check_value("ipi_set", data_t'(1), data_t'(ipi));
    bus_xfer(PortDbg, 1'b1, ClintBase + ClintMsipOff, 8'h01, 64'd0, rdata, err, gcyc);
    check_value("ipi_clear", '0, data_t'(ipi));

    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
rtl/bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/mem_bus_if.sv
rtl/bus_arbiter.sv
rtl/addr_decoder.sv
rtl/boot_rom.sv
rtl/sram_bank.sv
rtl/clint_timer.sv
rtl/soc_top.sv
bench/soc_properties.sv
bench/soc_tb.sv

//--- rtl/addr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module addr_decoder import bus_pkg::*, soc_map_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  mem_bus_if.slv      shared_bus,
  mem_bus_if.mst      rom_bus,
  mem_bus_if.mst      sram_bus,
  mem_bus_if.mst      clint_bus,
  output logic [31:0] exit_o
);

  tgt_sel_e    sel;
  tgt_sel_e    sel_q;
  logic        err_rvalid_q;
  logic        exit_hit;
  logic [31:0] exit_q;

  // Offsets wrap below the base, so one compare per region
  always_comb begin
    if ((shared_bus.addr - RomBase) < RomLength) begin
      sel = TGT_ROM;
    end else if ((shared_bus.addr - SramBase) < SramLength) begin
      sel = TGT_SRAM;
    end else if ((shared_bus.addr - ClintBase) < ClintLength) begin
      sel = TGT_CLINT;
    end else begin
      sel = TGT_ERR;
    end
  end

  // ------------------------------------------------
  // Forward request to the selected target
  // ------------------------------------------------
  assign rom_bus.req   = shared_bus.req & (sel == TGT_ROM);
  assign rom_bus.we    = shared_bus.we;
  assign rom_bus.addr  = shared_bus.addr;
  assign rom_bus.be    = shared_bus.be;
  assign rom_bus.wdata = shared_bus.wdata;

  assign sram_bus.req   = shared_bus.req & (sel == TGT_SRAM);
  assign sram_bus.we    = shared_bus.we;
  assign sram_bus.addr  = shared_bus.addr;
  assign sram_bus.be    = shared_bus.be;
  assign sram_bus.wdata = shared_bus.wdata;

  assign clint_bus.req   = shared_bus.req & (sel == TGT_CLINT);
  assign clint_bus.we    = shared_bus.we;
  assign clint_bus.addr  = shared_bus.addr;
  assign clint_bus.be    = shared_bus.be;
  assign clint_bus.wdata = shared_bus.wdata;

  always_comb begin
    case (sel)
      TGT_ROM:   shared_bus.gnt = rom_bus.gnt;
      TGT_SRAM:  shared_bus.gnt = sram_bus.gnt;
      TGT_CLINT: shared_bus.gnt = clint_bus.gnt;
      default:   shared_bus.gnt = shared_bus.req;
    endcase
  end

  // Response select follows the previous grant
  always_comb begin
    case (sel_q)
      TGT_ROM: begin
        shared_bus.rvalid = rom_bus.rvalid;
        shared_bus.rdata  = rom_bus.rdata;
        shared_bus.err    = rom_bus.err;
      end
      TGT_SRAM: begin
        shared_bus.rvalid = sram_bus.rvalid;
        shared_bus.rdata  = sram_bus.rdata;
        shared_bus.err    = sram_bus.err;
      end
      TGT_CLINT: begin
        shared_bus.rvalid = clint_bus.rvalid;
        shared_bus.rdata  = clint_bus.rdata;
        shared_bus.err    = clint_bus.err;
      end
      default: begin
        shared_bus.rvalid = err_rvalid_q;
        shared_bus.rdata  = '0;
        shared_bus.err    = err_rvalid_q;
      end
    endcase
  end

  assign exit_hit = shared_bus.gnt & shared_bus.we & (shared_bus.addr == ExitAddr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q        <= TGT_ERR;
      err_rvalid_q <= 1'b0;
      exit_q       <= '0;
    end else begin
      err_rvalid_q <= shared_bus.gnt & (sel == TGT_ERR);
      if (shared_bus.gnt) begin
        sel_q <= sel;
      end
      if (exit_hit) begin
        exit_q <= shared_bus.wdata[31:0];
      end
    end
  end

  assign exit_o = exit_q;

endmodule

`default_nettype wire

//--- rtl/boot_rom.sv
`timescale 1ns/10ps
`default_nettype none

module boot_rom import bus_pkg::*, soc_map_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  mem_bus_if.slv bus
);

  logic [RomIdxWidth-1:0] word_idx;
  logic                   rvalid_q;
  logic                   err_q;
  data_t                  rdata_q;

  assign word_idx = bus.addr[RomIdxWidth+ByteOffWidth-1:ByteOffWidth];

  // Always ready
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req & bus.we;
    end
  end

  // Content is generated from the word index
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : (RomSignature ^ data_t'(word_idx));
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

endmodule

`default_nettype wire

//--- rtl/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import bus_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  mem_bus_if.slv core_bus,
  mem_bus_if.slv dbg_bus,
  mem_bus_if.mst shared_bus
);

  mst_idx_t winner;
  mst_idx_t last_q;
  mst_idx_t owner_q;
  logic     core_owns;
  logic     dbg_owns;

  // Under contention the master not granted last wins
  always_comb begin
    if (core_bus.req && dbg_bus.req) begin
      winner = (last_q == MstCore) ? MstDbg : MstCore;
    end else if (dbg_bus.req) begin
      winner = MstDbg;
    end else begin
      winner = MstCore;
    end
  end

  // ------------------------------------------------
  // Request path
  // ------------------------------------------------
  assign shared_bus.req   = core_bus.req | dbg_bus.req;
  assign shared_bus.we    = (winner == MstDbg) ? dbg_bus.we    : core_bus.we;
  assign shared_bus.addr  = (winner == MstDbg) ? dbg_bus.addr  : core_bus.addr;
  assign shared_bus.be    = (winner == MstDbg) ? dbg_bus.be    : core_bus.be;
  assign shared_bus.wdata = (winner == MstDbg) ? dbg_bus.wdata : core_bus.wdata;

  assign core_bus.gnt = shared_bus.gnt & core_bus.req & (winner == MstCore);
  assign dbg_bus.gnt  = shared_bus.gnt & dbg_bus.req & (winner == MstDbg);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Core goes first after reset
      last_q  <= MstDbg;
      owner_q <= MstCore;
    end else begin
      owner_q <= winner;
      if (shared_bus.gnt) begin
        last_q <= winner;
      end
    end
  end

  // ------------------------------------------------
  // Response path
  // ------------------------------------------------
  assign core_owns = (owner_q == MstCore);
  assign dbg_owns  = (owner_q == MstDbg);

  assign core_bus.rvalid = shared_bus.rvalid & core_owns;
  assign core_bus.rdata  = core_owns ? shared_bus.rdata : '0;
  assign core_bus.err    = shared_bus.err & core_owns;

  assign dbg_bus.rvalid = shared_bus.rvalid & dbg_owns;
  assign dbg_bus.rdata  = dbg_owns ? shared_bus.rdata : '0;
  assign dbg_bus.err    = shared_bus.err & dbg_owns;

endmodule

`default_nettype wire

//--- rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Master index on the shared bus
  typedef logic mst_idx_t;
  localparam mst_idx_t MstCore = 1'b0;
  localparam mst_idx_t MstDbg  = 1'b1;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_CLINT,
    TGT_ERR
  } tgt_sel_e;

  // Merge enabled bytes of new_val into old_val
  function automatic data_t apply_be(data_t old_val, data_t new_val, strb_t be);
    data_t res;
    res = old_val;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- rtl/clint_timer.sv
`timescale 1ns/10ps
`default_nettype none

module clint_timer import bus_pkg::*, soc_map_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   rtc_i,
  mem_bus_if.slv bus,
  output logic   timer_irq_o,
  output logic   ipi_o
);

  addr_t      offset;
  logic       hit_msip;
  logic       hit_cmp;
  logic       hit_time;
  logic       wr_en;
  data_t      rd_word;
  logic [2:0] rtc_q;
  logic       rtc_rise;
  logic       tick_q;
  data_t      mtime_q;
  data_t      mtimecmp_q;
  logic       msip_q;
  logic       rvalid_q;
  data_t      rdata_q;

  // ------------------------------------------------
  // RTC synchronizer and edge detect
  // ------------------------------------------------
  // Two sync flops plus one history flop
  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q  <= '0;
      tick_q <= 1'b0;
    end else begin
      rtc_q  <= {rtc_q[1:0], rtc_i};
      tick_q <= rtc_rise;
    end
  end

  // ------------------------------------------------
  // Register access
  // ------------------------------------------------
  assign offset   = bus.addr - ClintBase;
  assign hit_msip = (offset[31:3] == ClintMsipOff[31:3]);
  assign hit_cmp  = (offset[31:3] == ClintMtimecmpOff[31:3]);
  assign hit_time = (offset[31:3] == ClintMtimeOff[31:3]);
  assign wr_en    = bus.req & bus.we;

  always_comb begin
    if (hit_msip) begin
      rd_word = data_t'(msip_q);
    end else if (hit_cmp) begin
      rd_word = mtimecmp_q;
    end else if (hit_time) begin
      rd_word = mtime_q;
    end else begin
      rd_word = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      // All ones keeps the timer interrupt quiet
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (tick_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && hit_cmp) begin
        mtimecmp_q <= apply_be(mtimecmp_q, bus.wdata, bus.be);
      end
      if (wr_en && hit_msip && bus.be[0]) begin
        msip_q <= bus.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : rd_word;
    end
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

//--- rtl/mem_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if import bus_pkg::*; ();

  // Request side
  logic  req;
  logic  we;
  addr_t addr;
  strb_t be;
  data_t wdata;

  // Grant and response side
  logic  gnt;
  logic  rvalid;
  data_t rdata;
  logic  err;

  modport mst (
    output req, we, addr, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport slv (
    input  req, we, addr, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

//--- rtl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  // ------------------------------------------------
  // Boot ROM
  // ------------------------------------------------
  localparam logic [31:0] RomBase     = 32'h0001_0000;
  localparam int unsigned RomWords    = 512;
  localparam logic [31:0] RomLength   = 32'(RomWords * 8);
  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  // Word k reads as signature XOR k
  localparam logic [63:0] RomSignature = 64'h0000_0013_0000_0013;

  // ------------------------------------------------
  // SRAM
  // ------------------------------------------------
  localparam logic [31:0] SramBase   = 32'h8000_0000;
  localparam int unsigned SramWords  = 2048;
  localparam logic [31:0] SramLength = 32'(SramWords * 8);

  // Last SRAM word doubles as the exit word
  localparam logic [31:0] ExitAddr = SramBase + 32'h0000_3FF8;

  // ------------------------------------------------
  // CLINT
  // ------------------------------------------------
  localparam logic [31:0] ClintBase        = 32'h0200_0000;
  localparam logic [31:0] ClintLength      = 32'h0000_C000;
  localparam logic [31:0] ClintMsipOff     = 32'h0000_0000;
  localparam logic [31:0] ClintMtimecmpOff = 32'h0000_4000;
  localparam logic [31:0] ClintMtimeOff    = 32'h0000_BFF8;

endpackage

`default_nettype wire

//--- rtl/soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_top import bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rtc_i,
  // Core master port
  input  logic        core_req_i,
  input  logic        core_we_i,
  input  addr_t       core_addr_i,
  input  strb_t       core_be_i,
  input  data_t       core_wdata_i,
  output logic        core_gnt_o,
  output logic        core_rvalid_o,
  output data_t       core_rdata_o,
  output logic        core_err_o,
  // Debug master port
  input  logic        dbg_req_i,
  input  logic        dbg_we_i,
  input  addr_t       dbg_addr_i,
  input  strb_t       dbg_be_i,
  input  data_t       dbg_wdata_i,
  output logic        dbg_gnt_o,
  output logic        dbg_rvalid_o,
  output data_t       dbg_rdata_o,
  output logic        dbg_err_o,
  output logic [31:0] exit_o,
  output logic        timer_irq_o,
  output logic        ipi_o
);

  mem_bus_if core_bus ();
  mem_bus_if dbg_bus ();
  mem_bus_if shared_bus ();
  mem_bus_if rom_bus ();
  mem_bus_if sram_bus ();
  mem_bus_if clint_bus ();

  // ------------------------------------------------
  // Master ports onto interfaces
  // ------------------------------------------------
  assign core_bus.req   = core_req_i;
  assign core_bus.we    = core_we_i;
  assign core_bus.addr  = core_addr_i;
  assign core_bus.be    = core_be_i;
  assign core_bus.wdata = core_wdata_i;
  assign core_gnt_o     = core_bus.gnt;
  assign core_rvalid_o  = core_bus.rvalid;
  assign core_rdata_o   = core_bus.rdata;
  assign core_err_o     = core_bus.err;

  assign dbg_bus.req   = dbg_req_i;
  assign dbg_bus.we    = dbg_we_i;
  assign dbg_bus.addr  = dbg_addr_i;
  assign dbg_bus.be    = dbg_be_i;
  assign dbg_bus.wdata = dbg_wdata_i;
  assign dbg_gnt_o     = dbg_bus.gnt;
  assign dbg_rvalid_o  = dbg_bus.rvalid;
  assign dbg_rdata_o   = dbg_bus.rdata;
  assign dbg_err_o     = dbg_bus.err;

  bus_arbiter i_bus_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .core_bus   ( core_bus   ),
    .dbg_bus    ( dbg_bus    ),
    .shared_bus ( shared_bus )
  );

  addr_decoder i_addr_decoder (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .shared_bus ( shared_bus ),
    .rom_bus    ( rom_bus    ),
    .sram_bus   ( sram_bus   ),
    .clint_bus  ( clint_bus  ),
    .exit_o     ( exit_o     )
  );

  boot_rom i_boot_rom (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .bus    ( rom_bus )
  );

  sram_bank i_sram_bank (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .bus    ( sram_bus )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .bus         ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

`default_nettype wire

//--- rtl/sram_bank.sv
`timescale 1ns/10ps
`default_nettype none

module sram_bank import bus_pkg::*, soc_map_pkg::*; #(
  parameter int unsigned NumWords = SramWords
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  mem_bus_if.slv bus
);

  data_t                       mem_q [NumWords];
  logic [$clog2(NumWords)-1:0] word_idx;
  logic                        rvalid_q;
  data_t                       rdata_q;

  assign word_idx = bus.addr[$clog2(NumWords)+ByteOffWidth-1:ByteOffWidth];

  assign bus.gnt = bus.req;

  // Single port, write returns zero data
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        mem_q[word_idx] <= apply_be(mem_q[word_idx], bus.wdata, bus.be);
        rdata_q         <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  // No error case in SRAM
  assign bus.err    = 1'b0;

endmodule

`default_nettype wire
